/* hw/shade_pkg.sv */
package shade_pkg;

    // Ray slots handled in one pass
    localparam int rpp = 16;
    localparam int rpp_width = 4;

    // Up to 8 spheres in the scene
    localparam int spheres_width = 3;

    // Unsigned fixed point colour channel with 1.0 at 16'h8000
    localparam int chan_width = 16;
    localparam int chan_frac = 15;
    localparam logic [chan_width-1:0] chan_max = '1;

    // Pipeline latencies in clock cycles
    localparam int mul_latency = 2;
    localparam int rom_latency = 1;
    localparam int fetch_latency = 1;
    // Issue to store
    localparam int shade_latency = 5;

    typedef struct packed {
        logic [chan_width-1:0] r;
        logic [chan_width-1:0] g;
        logic [chan_width-1:0] b;
    } color_t;

    // One record per sphere with emission in the upper half
    typedef struct packed {
        color_t emission;
        color_t albedo;
    } material_t;

    // Sky colour seen by rays that leave the scene (0.5, 0.7, 1.0)
    localparam color_t background_emission = '{
        r: 16'h4000,
        g: 16'h599a,
        b: 16'h8000
    };

    typedef enum logic [1:0] {
        seq_idle,
        seq_issue,
        seq_drain
    } seq_state_t;

endpackage

/* hw/shade_seq_if.sv */
`timescale 1ns/1ps

interface shade_seq_if
    import shade_pkg::*;
();
    // Slot issue from the sequencer
    logic                 issue;
    logic [rpp_width-1:0] issue_ndx;

    // Slot completion from the datapath
    logic                 result_vld;
    logic [rpp_width-1:0] result_ndx;

    modport seq (
        output issue, issue_ndx,
        input  result_vld, result_ndx
    );

    modport dp (
        input  issue, issue_ndx,
        output result_vld, result_ndx
    );
endinterface

/* hw/delay_line.sv */
`timescale 1ns/1ps

module delay_line
#(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1
)
(
    input  logic             clk,
    input  logic [WIDTH-1:0] d,
    output logic [WIDTH-1:0] q
);
    logic [WIDTH-1:0] stages [DEPTH];

    always_ff @(posedge clk)
    begin
        stages[0] <= d;
        for (int i = 1; i < DEPTH; i++)
        begin
            stages[i] <= stages[i-1];
        end
    end

    // Oldest entry leaves the chain
    assign q = stages[DEPTH-1];

endmodule

/* hw/material_rom.sv */
`timescale 1ns/1ps

module material_rom
    import shade_pkg::*;
(
    input  logic                     clk,
    input  logic [spheres_width-1:0] addr,
    output material_t                data
);
    logic [$bits(material_t)-1:0] table_mem [2**spheres_width];

    // Scene materials, one record per sphere id
    initial
    begin
        $readmemh("material_data.mem", table_mem);
    end

    // Registered read
    always_ff @(posedge clk)
    begin
        data <= table_mem[addr];
    end

endmodule

/* hw/shade_seq.sv */
`timescale 1ns/1ps

module shade_seq
    import shade_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    output logic                 busy,
    output logic [rpp_width-1:0] fetch_hit_info_ndx,
    shade_seq_if.seq             seq,
    output logic [rpp_width-1:0] store_data_ndx,
    output logic                 store_data_wr_en
);
    seq_state_t           state;
    logic [rpp_width-1:0] ray_ctr;
    logic                 last_issue;
    logic                 last_store;

    assign last_issue = (ray_ctr == rpp_width'(rpp - 1));
    assign last_store = seq.result_vld && (seq.result_ndx == rpp_width'(rpp - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= seq_idle;
            ray_ctr <= '0;
        end
        else
        begin
            case (state)
                seq_idle:
                begin
                    ray_ctr <= '0;
                    if (start)
                        state <= seq_issue;
                end
                seq_issue:
                begin
                    // One slot per clock
                    ray_ctr <= ray_ctr + 1'b1;
                    if (last_issue)
                        state <= seq_drain;
                end
                seq_drain:
                begin
                    // Wait for the pipeline to empty
                    if (last_store)
                        state <= seq_idle;
                end
                default:
                    state <= seq_idle;
            endcase
        end
    end

    assign busy = (state != seq_idle);
    assign seq.issue = (state == seq_issue);
    assign seq.issue_ndx = ray_ctr;
    assign fetch_hit_info_ndx = ray_ctr;

    // Store straight from the completion side of the pipeline
    assign store_data_wr_en = seq.result_vld;
    assign store_data_ndx = seq.result_ndx;

endmodule

/* hw/color_update.sv */
`timescale 1ns/1ps

module color_update
    import shade_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    shade_seq_if.dp              dp,
    input  logic                 hit,
    input  material_t            material,
    input  color_t               ray_f_current,
    input  color_t               ray_l_current,
    output logic [rpp_width-1:0] fetch_ray_color_ndx,
    output logic                 ray_hit,
    output color_t               ray_f_new,
    output color_t               ray_l_new
);
    logic [shade_latency-1:0]      vld_pipe;
    logic                          hit_sel;
    color_t                        l_dly;
    logic [2:0][chan_width-1:0]    f_ch;
    logic [2:0][chan_width-1:0]    emis_ch;
    logic [2:0][chan_width-1:0]    albd_ch;
    logic [2:0][chan_width-1:0]    l_ch;
    logic [2:0][2*chan_width-1:0]  emis_prod;
    logic [2:0][2*chan_width-1:0]  albd_prod;
    logic [2:0][chan_width-1:0]    emis_sat;
    logic [2:0][chan_width-1:0]    albd_sat;
    logic [2:0][chan_width-1:0]    l_sum;

    // Clamp a value with one carry bit to the channel range
    function automatic logic [chan_width-1:0] sat_chan(input logic [chan_width:0] v);
        return v[chan_width] ? chan_max : v[chan_width-1:0];
    endfunction

    // Slot index for the colour fetch and then on to the store
    delay_line #(.WIDTH(rpp_width), .DEPTH(fetch_latency)) dly_fetch_ndx (
        .clk(clk),
        .d(dp.issue_ndx),
        .q(fetch_ray_color_ndx)
    );

    delay_line #(.WIDTH(rpp_width), .DEPTH(shade_latency - fetch_latency)) dly_result_ndx (
        .clk(clk),
        .d(fetch_ray_color_ndx),
        .q(dp.result_ndx)
    );

    // Hit flag lines up with the ROM output
    delay_line #(.WIDTH(1), .DEPTH(rom_latency)) dly_hit_sel (
        .clk(clk),
        .d(hit),
        .q(hit_sel)
    );

    delay_line #(.WIDTH(1), .DEPTH(shade_latency - fetch_latency - rom_latency)) dly_hit_out (
        .clk(clk),
        .d(hit_sel),
        .q(ray_hit)
    );

    // L waits for the emission product
    delay_line #(.WIDTH($bits(color_t)), .DEPTH(mul_latency)) dly_l (
        .clk(clk),
        .d(ray_l_current),
        .q(l_dly)
    );

    // Misses see the sky and absorb everything
    assign emis_ch = hit_sel ? material.emission : background_emission;
    assign albd_ch = hit_sel ? material.albedo : '0;
    assign f_ch = ray_f_current;
    assign l_ch = l_dly;

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 3; i++)
        begin
            // Full products first
            emis_prod[i] <= f_ch[i] * emis_ch[i];
            albd_prod[i] <= f_ch[i] * albd_ch[i];
            // Then back to the channel format
            emis_sat[i] <= sat_chan((chan_width+1)'(emis_prod[i] >> chan_frac));
            albd_sat[i] <= sat_chan((chan_width+1)'(albd_prod[i] >> chan_frac));
            // Radiance accumulates last
            l_sum[i] <= sat_chan({1'b0, l_ch[i]} + {1'b0, emis_sat[i]});
        end
    end

    // Throughput skips the adder stage
    delay_line #(
        .WIDTH(3*chan_width),
        .DEPTH(shade_latency - fetch_latency - rom_latency - mul_latency)
    ) dly_albedo (
        .clk(clk),
        .d(albd_sat),
        .q(ray_f_new)
    );

    assign ray_l_new = l_sum;

    always_ff @(posedge clk)
    begin
        if (rst)
            vld_pipe <= '0;
        else
            vld_pipe <= {vld_pipe[shade_latency-2:0], dp.issue};
    end

    assign dp.result_vld = vld_pipe[shade_latency-1];

endmodule

/* hw/shade_rays_top.sv */
`timescale 1ns/1ps

module shade_rays_top
    import shade_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    output logic                     busy,
    // Hit record fetch
    output logic [rpp_width-1:0]     fetch_hit_info_ndx,
    input  logic                     hit,
    input  logic [spheres_width-1:0] sphere_id,
    // Current F and L fetch
    output logic [rpp_width-1:0]     fetch_ray_color_ndx,
    input  color_t                   ray_f_current,
    input  color_t                   ray_l_current,
    // Result store
    output logic                     store_data_wr_en,
    output logic [rpp_width-1:0]     store_data_ndx,
    output logic                     ray_hit,
    output color_t                   ray_f_new,
    output color_t                   ray_l_new
);
    material_t material;

    shade_seq_if seq_if ();

    shade_seq shade_seq_i (
        .clk(clk),
        .rst(rst),
        .start(start),
        .busy(busy),
        .fetch_hit_info_ndx(fetch_hit_info_ndx),
        .seq(seq_if.seq),
        .store_data_ndx(store_data_ndx),
        .store_data_wr_en(store_data_wr_en)
    );

    // Sphere id arrives with the hit record
    material_rom material_rom_i (
        .clk(clk),
        .addr(sphere_id),
        .data(material)
    );

    color_update color_update_i (
        .clk(clk),
        .rst(rst),
        .dp(seq_if.dp),
        .hit(hit),
        .material(material),
        .ray_f_current(ray_f_current),
        .ray_l_current(ray_l_current),
        .fetch_ray_color_ndx(fetch_ray_color_ndx),
        .ray_hit(ray_hit),
        .ray_f_new(ray_f_new),
        .ray_l_new(ray_l_new)
    );

endmodule

/* dv/tb_shade_rays.sv */
`timescale 1ns/1ps

module tb_shade_rays
    import shade_pkg::*;
();
    localparam int passes = 8;
    localparam int gap_max = 7;
    localparam int timeout_cycles = passes * (rpp + 5 + gap_max + 4) + 50;

    logic                     clk;
    logic                     rst;
    logic                     start;
    logic                     busy;
    logic [rpp_width-1:0]     fetch_hit_info_ndx;
    logic                     hit = 1'b0;
    logic [spheres_width-1:0] sphere_id = '0;
    logic [rpp_width-1:0]     fetch_ray_color_ndx;
    color_t                   ray_f_current = '0;
    color_t                   ray_l_current = '0;
    logic                     store_data_wr_en;
    logic [rpp_width-1:0]     store_data_ndx;
    logic                     ray_hit;
    color_t                   ray_f_new;
    color_t                   ray_l_new;

    // Scene data for the current pass with one entry per slot
    logic                     hit_mem [rpp];
    logic [spheres_width-1:0] sid_mem [rpp];
    color_t                   f_mem [rpp];
    color_t                   l_mem [rpp];
    // Emission sits at index 1 and albedo at index 0
    logic [1:0][$bits(color_t)-1:0] mat_model [2**spheres_width];

    logic [31:0] rng_state;
    int          n_checks = 0;
    int          n_errors = 0;
    int          sat_events = 0;
    int          passes_done = 0;
    int          pass_rel = 0;
    int          store_cnt [rpp];

    shade_rays_top shade_rays_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // About one channel in eight sits near full scale
    function automatic logic [chan_width-1:0] random_chan();
        logic [31:0] r;
        r = next_rand();
        if (r[31:29] == 3'd0)
            return {4'hf, r[11:0]};
        return r[chan_width-1:0];
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("[FAIL] %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // One 1.15 channel gives L + F*e and F*a, both clamped at all ones
    task automatic model_chan(input logic [15:0] f, input logic [15:0] l,
                              input logic [15:0] e, input logic [15:0] a,
                              output logic [15:0] l_new, output logic [15:0] f_new,
                              output logic sat);
        logic [31:0] pe;
        logic [31:0] pa;
        logic [31:0] sum;
        sat = 1'b0;
        pe = (32'(f) * 32'(e)) >> 15;
        pa = (32'(f) * 32'(a)) >> 15;
        if (pe > 32'hffff)
        begin
            pe = 32'hffff;
            sat = 1'b1;
        end
        if (pa > 32'hffff)
        begin
            pa = 32'hffff;
            sat = 1'b1;
        end
        sum = 32'(l) + pe;
        if (sum > 32'hffff)
        begin
            sum = 32'hffff;
            sat = 1'b1;
        end
        l_new = sum[15:0];
        f_new = pa[15:0];
    endtask

    task automatic check_store(input int k);
        color_t em;
        color_t al;
        color_t exp_l;
        color_t exp_f;
        logic   sat_r;
        logic   sat_g;
        logic   sat_b;
        if (hit_mem[k])
        begin
            em = mat_model[sid_mem[k]][1];
            al = mat_model[sid_mem[k]][0];
        end
        else
        begin
            em = background_emission;
            al = '0;
        end
        model_chan(f_mem[k].r, l_mem[k].r, em.r, al.r, exp_l.r, exp_f.r, sat_r);
        model_chan(f_mem[k].g, l_mem[k].g, em.g, al.g, exp_l.g, exp_f.g, sat_g);
        model_chan(f_mem[k].b, l_mem[k].b, em.b, al.b, exp_l.b, exp_f.b, sat_b);
        if (sat_r || sat_g || sat_b)
            sat_events++;
        check(64'(store_data_ndx), 64'(k), "store index");
        check(64'(ray_hit), 64'(hit_mem[k]), $sformatf("slot %0d hit flag", k));
        check(64'(ray_l_new), 64'(exp_l), $sformatf("slot %0d new radiance", k));
        check(64'(ray_f_new), 64'(exp_f), $sformatf("slot %0d new throughput", k));
    endtask

    task automatic fill_pass();
        logic [31:0] r;
        for (int k = 0; k < rpp; k++)
        begin
            r = next_rand();
            hit_mem[k] = (r[1:0] != 2'b00);
            sid_mem[k] = r[4 +: spheres_width];
            f_mem[k] = {random_chan(), random_chan(), random_chan()};
            l_mem[k] = {random_chan(), random_chan(), random_chan()};
        end
    endtask

    // Hit records and ray colours with one cycle of read latency
    always @(posedge clk)
    begin
        hit <= hit_mem[fetch_hit_info_ndx];
        sphere_id <= sid_mem[fetch_hit_info_ndx];
        ray_f_current <= f_mem[fetch_ray_color_ndx];
        ray_l_current <= l_mem[fetch_ray_color_ndx];
    end

    // Edge by edge against the schedule counted from the start edge
    always @(posedge clk)
    begin
        if (rst)
        begin
            pass_rel = 0;
        end
        else if (pass_rel == 0)
        begin
            check(64'(busy), 64'd0, "busy while idle");
            check(64'(store_data_wr_en), 64'd0, "store strobe while idle");
            if (start)
            begin
                pass_rel = 1;
                foreach (store_cnt[k])
                    store_cnt[k] = 0;
            end
        end
        else
        begin
            if (pass_rel <= rpp)
                check(64'(fetch_hit_info_ndx), 64'(pass_rel - 1), "hit record fetch index");
            if (pass_rel >= 2 && pass_rel <= rpp + 1)
                check(64'(fetch_ray_color_ndx), 64'(pass_rel - 2), "ray colour fetch index");
            check(64'(busy), 64'(pass_rel <= rpp + 5), $sformatf("busy at step %0d", pass_rel));
            check(64'(store_data_wr_en), 64'(pass_rel >= 6 && pass_rel <= rpp + 5),
                  $sformatf("store strobe at step %0d", pass_rel));
            if (store_data_wr_en)
                store_cnt[store_data_ndx]++;
            if (pass_rel >= 6 && pass_rel <= rpp + 5)
                check_store(pass_rel - 6);
            if (pass_rel == rpp + 6)
            begin
                foreach (store_cnt[k])
                    check(64'(store_cnt[k]), 64'd1, $sformatf("slot %0d store count", k));
                passes_done <= passes_done + 1;
                pass_rel = 0;
            end
            else
            begin
                pass_rel++;
            end
        end
    end

    initial
    begin
        int gap;
        rng_state = 32'h91af_59de;
        start = 1'b0;
        rst = 1'b1;
        $readmemh("material_data.mem", mat_model);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int p = 0; p < passes; p++)
        begin
            fill_pass();
            gap = int'(next_rand() % (gap_max + 1));
            repeat (gap + 1) @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            while (passes_done <= p)
                @(posedge clk);
        end
        check(64'(sat_events != 0), 64'd1, "no saturating channel was exercised");
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the passes did not finish within %0d cycles", timeout_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

/* sim.f */
hw/shade_pkg.sv
hw/shade_seq_if.sv
hw/delay_line.sv
hw/material_rom.sv
hw/shade_seq.sv
hw/color_update.sv
hw/shade_rays_top.sv
dv/tb_shade_rays.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_shade_rays
FILELIST   ?= sim.f
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the log holds the pass line
run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* material_data.mem */
// Material per sphere id 0 to 7, one 96-bit word per line
// Columns: emission r g b, then albedo r g b, 16 bits each, 1.0 is 8000
000000000000666666666666
00000000000073334ccd3333
800080008000000000000000
ffffe000c000100010001000
000000000000ffffffffffff
199a0ccd000040008000c000
000040000000800080008000
ffffffffffffffffffffffff
